//--- source/rs_pkg.sv
// Shared types for the station; tag and ROB widths follow PRF_SIZE and ROB_SIZE, both powers of two
package rs_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int XLEN      = 64;                 // Operand width
	localparam int PRF_SIZE  = 64;                 // Physical registers
	localparam int PRF_TAG_W = $clog2(PRF_SIZE);   // 6 bit tag
	localparam int ROB_SIZE  = 32;                 // Reorder buffer entries
	localparam int ROB_IDX_W = $clog2(ROB_SIZE);   // 5 bit index
	localparam int OP_TYPE_W = 6;                  // Decoder op type

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		ALU_DEFAULT = 5'h00,   // Idle, also the empty issue value
		ALU_ADDQ    = 5'h01,
		ALU_SUBQ    = 5'h02,
		ALU_MULQ    = 5'h03,   // Only this one goes to the multiplier
		ALU_AND     = 5'h04,
		ALU_OR      = 5'h05
	} alu_func_e;

	typedef enum logic [1:0] {
		USE_DEFAULT    = 2'd0,   // No instruction offered
		USE_ADDER      = 2'd1,
		USE_MULTIPLIER = 2'd2,
		USE_MEMORY     = 2'd3
	} fu_select_e;

	////////////////////////////////////////////////////////////
	// Operand word, value or tag depending on ready
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [XLEN-PRF_TAG_W-1:0] pad;   // Don't care while waiting
		logic [PRF_TAG_W-1:0]      tag;   // Producer's physical register
	} tag_view_t;

	typedef union packed {
		logic [XLEN-1:0] value;   // Valid once ready
		tag_view_t       tv;      // Valid while not ready
	} operand_t;

	typedef struct packed {
		operand_t word;
		logic     ready;   // Word holds a value
	} src_t;

	////////////////////////////////////////////////////////////
	// Bus structs
	////////////////////////////////////////////////////////////
	typedef struct packed {
		src_t                 opa;
		src_t                 opb;
		logic [PRF_TAG_W-1:0] dest;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [OP_TYPE_W-1:0] op_type;
		alu_func_e            alu_func;
	} dispatch_t;

	typedef struct packed {
		logic                 valid;
		logic [PRF_TAG_W-1:0] tag;
		logic [XLEN-1:0]      value;
	} cdb_t;

	typedef struct packed {
		src_t                 opa;
		src_t                 opb;
		logic [PRF_TAG_W-1:0] dest;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [OP_TYPE_W-1:0] op_type;
		alu_func_e            alu_func;
		fu_select_e           fu;   // Unit class fixed at dispatch
	} slot_t;

	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		logic [PRF_TAG_W-1:0] dest;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [OP_TYPE_W-1:0] op_type;
		alu_func_e            alu_func;
	} issue_t;

	typedef struct packed {
		logic mult;
		logic adder;
		logic memory;
	} fu_avail_t;

endpackage

//--- source/rs_entry.sv
// One station slot; alloc and issue never hit the same slot in one cycle, cdb1 wins a tag tie
module rs_entry (
	input  logic              clock,
	input  logic              rst_n,
	input  rs_pkg::dispatch_t disp,       // Instruction offered this cycle
	input  rs_pkg::fu_select_e fu_class,  // Its decoded unit
	input  logic              alloc,      // This slot takes disp
	input  logic              issue,      // This slot leaves at the edge
	input  rs_pkg::cdb_t      cdb1,
	input  rs_pkg::cdb_t      cdb2,
	output logic              busy,
	output logic              ready,
	output rs_pkg::slot_t     slot
);
	import rs_pkg::*;

	////////////////////////////////////////////////////////////
	// Tag match against both broadcasts
	////////////////////////////////////////////////////////////
	function automatic src_t capture(
		input src_t s,
		input cdb_t c1,
		input cdb_t c2
	);
		src_t r;
		r = s;
		if (!s.ready) begin
			if (c1.valid && (c1.tag == s.word.tv.tag)) begin   // cdb1 first
				r.word.value = c1.value;
				r.ready      = 1'b1;
			end else if (c2.valid && (c2.tag == s.word.tv.tag)) begin
				r.word.value = c2.value;
				r.ready      = 1'b1;
			end
		end
		return r;
	endfunction

	src_t opa_next;   // Operand a after this edge's capture
	src_t opb_next;

	// Source of the capture is disp on alloc, else the held operands
	always_comb begin
		if (alloc) begin
			opa_next = capture(disp.opa, cdb1, cdb2);
			opb_next = capture(disp.opb, cdb1, cdb2);
		end else begin
			opa_next = capture(slot.opa, cdb1, cdb2);
			opb_next = capture(slot.opb, cdb1, cdb2);
		end
	end

	////////////////////////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;             // All slots free
		end else if (alloc) begin
			busy <= 1'b1;
		end else if (issue) begin
			busy <= 1'b0;             // Freed as the unit takes it
		end
	end

	////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (alloc) begin
			slot.opa      <= opa_next;
			slot.opb      <= opb_next;
			slot.dest     <= disp.dest;
			slot.rob_idx  <= disp.rob_idx;
			slot.op_type  <= disp.op_type;
			slot.alu_func <= disp.alu_func;
			slot.fu       <= fu_class;   // Class frozen here
		end else if (busy) begin
			slot.opa <= opa_next;      // Waiting operands fill in
			slot.opb <= opb_next;
		end
	end

	// Ready in the cycle after the last operand arrives
	assign ready = busy && slot.opa.ready && slot.opb.ready;

endmodule

//--- source/rs_control.sv
// Combinational control only; a load while full is dropped even if a slot issues that same cycle
module rs_control #(
	parameter int RS_SIZE = 4
) (
	input  rs_pkg::dispatch_t  disp,
	input  logic               load,
	input  rs_pkg::fu_avail_t  avail,
	input  logic [RS_SIZE-1:0] busy,
	input  logic [RS_SIZE-1:0] ready,
	input  rs_pkg::fu_select_e slot_fu [RS_SIZE],   // Stored class per slot
	output logic [RS_SIZE-1:0] alloc_gnt,
	output logic [RS_SIZE-1:0] issue_gnt,
	output rs_pkg::fu_select_e fu_class,
	output logic               full
);
	import rs_pkg::*;

	logic [RS_SIZE-1:0] unit_ok;   // Slot's unit can accept now
	logic [2:0]         op_group;  // Upper op type bits

	////////////////////////////////////////////////////////////
	// Lowest index first
	////////////////////////////////////////////////////////////
	function automatic logic [RS_SIZE-1:0] pick_lowest(input logic [RS_SIZE-1:0] req);
		logic [RS_SIZE-1:0] gnt;
		logic               found;
		gnt   = '0;
		found = 1'b0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (req[i] && !found) begin
				gnt[i] = 1'b1;   // First requester wins
				found  = 1'b1;
			end
		end
		return gnt;
	endfunction

	////////////////////////////////////////////////////////////
	// Unit classification
	////////////////////////////////////////////////////////////
	assign op_group = disp.op_type[OP_TYPE_W-1:OP_TYPE_W-3];

	always_comb begin
		if (!load) begin
			fu_class = USE_DEFAULT;   // Nothing offered
		end else if ((op_group == 3'b010) && (disp.alu_func == ALU_MULQ)) begin
			fu_class = USE_MULTIPLIER;
		end else if ((op_group == 3'b001) || (op_group == 3'b100) || (op_group == 3'b101)) begin
			fu_class = USE_MEMORY;    // Loads and stores
		end else begin
			fu_class = USE_ADDER;
		end
	end

	// Back-pressure per slot
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			case (slot_fu[i])
				USE_MULTIPLIER: unit_ok[i] = avail.mult;
				USE_ADDER:      unit_ok[i] = avail.adder;
				USE_MEMORY:     unit_ok[i] = avail.memory;
				default:        unit_ok[i] = 1'b0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pickers and full
	////////////////////////////////////////////////////////////
	assign full      = &busy;   // No free slot left
	assign alloc_gnt = (load && !full) ? pick_lowest(~busy) : '0;
	assign issue_gnt = pick_lowest(ready & unit_ok);   // Blocked units are skipped

endmodule

//--- source/rs_issue_mux.sv
// Expects a one-hot or zero grant; more than one bit would OR slot contents together
module rs_issue_mux #(
	parameter int RS_SIZE = 4
) (
	input  rs_pkg::slot_t      slots [RS_SIZE],
	input  logic [RS_SIZE-1:0] issue_gnt,
	output rs_pkg::issue_t     iss
);
	import rs_pkg::*;

	// AND-OR select of the granted slot
	always_comb begin
		iss          = '0;
		iss.alu_func = ALU_DEFAULT;   // Idle value, encodes as zero
		for (int i = 0; i < RS_SIZE; i++) begin
			if (issue_gnt[i]) begin
				iss.opa      = iss.opa | slots[i].opa.word.value;   // Ready, so a value
				iss.opb      = iss.opb | slots[i].opb.word.value;
				iss.dest     = iss.dest | slots[i].dest;
				iss.rob_idx  = iss.rob_idx | slots[i].rob_idx;
				iss.op_type  = iss.op_type | slots[i].op_type;
				iss.alu_func = alu_func_e'(iss.alu_func | slots[i].alu_func);
			end
		end
		iss.valid = |issue_gnt;   // Any grant presents an instruction
	end

endmodule

//--- source/rs_top.sv
// Station top; issue is combinational and the unit must take iss whenever its avail bit is high
module rs_top #(
	parameter int RS_SIZE = 4
) (
	input  logic              clock,
	input  logic              rst_n,
	input  rs_pkg::dispatch_t disp,    // From rename
	input  logic              load,    // Dispatch request
	input  rs_pkg::cdb_t      cdb1,
	input  rs_pkg::cdb_t      cdb2,
	input  rs_pkg::fu_avail_t avail,   // Unit back-pressure
	output rs_pkg::issue_t    iss,
	output logic              full
);
	import rs_pkg::*;

	////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////
	logic [RS_SIZE-1:0] alloc_gnt;   // One-hot write enable
	logic [RS_SIZE-1:0] issue_gnt;   // One-hot issue select
	logic [RS_SIZE-1:0] busy;
	logic [RS_SIZE-1:0] ready;
	fu_select_e         fu_class;    // Class of disp
	fu_select_e         slot_fu [RS_SIZE];
	slot_t              slots [RS_SIZE];

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	rs_control #(
		.RS_SIZE(RS_SIZE)
	) u_control (
		.disp     (disp),
		.load     (load),
		.avail    (avail),
		.busy     (busy),
		.ready    (ready),
		.slot_fu  (slot_fu),
		.alloc_gnt(alloc_gnt),
		.issue_gnt(issue_gnt),
		.fu_class (fu_class),
		.full     (full)
	);

	////////////////////////////////////////////////////////////
	// Slot array
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < RS_SIZE; i++) begin : g_slot
		rs_entry u_entry (
			.clock   (clock),
			.rst_n   (rst_n),
			.disp    (disp),
			.fu_class(fu_class),
			.alloc   (alloc_gnt[i]),
			.issue   (issue_gnt[i]),
			.cdb1    (cdb1),
			.cdb2    (cdb2),
			.busy    (busy[i]),
			.ready   (ready[i]),
			.slot    (slots[i])
		);

		assign slot_fu[i] = slots[i].fu;   // Stored class back to control
	end

	// Issue bus
	rs_issue_mux #(
		.RS_SIZE(RS_SIZE)
	) u_issue_mux (
		.slots    (slots),
		.issue_gnt(issue_gnt),
		.iss      (iss)
	);

endmodule

//--- tests/rs_checker.sv
// Model of the slots, compared at each rising edge before the edge moves it; idle iss is not checked
module rs_checker #(
	parameter int RS_SIZE = 4
) (
	input  logic              clock,
	input  logic              rst_n,
	input  rs_pkg::dispatch_t disp,
	input  logic              load,
	input  rs_pkg::cdb_t      cdb1,
	input  rs_pkg::cdb_t      cdb2,
	input  rs_pkg::fu_avail_t avail,
	input  rs_pkg::issue_t    iss,
	input  logic              full,
	output int                errors,
	output int                checks,
	output int                held     // Occupied model slots
);
	import rs_pkg::*;

	slot_t              m [RS_SIZE];   // Model slot contents
	logic [RS_SIZE-1:0] m_busy;
	int                 err_cnt = 0;
	int                 chk_cnt = 0;
	int                 held_cnt = 0;

	assign errors = err_cnt;
	assign checks = chk_cnt;
	assign held   = held_cnt;

	////////////////////////////////////////////////////////////
	// Rules
	////////////////////////////////////////////////////////////
	function automatic fu_select_e classify(input logic [5:0] op, input alu_func_e f);
		if ((op[5:3] == 3'b010) && (f == ALU_MULQ))
			return USE_MULTIPLIER;
		if ((op[5:3] == 3'b001) || (op[5:3] == 3'b100) || (op[5:3] == 3'b101))
			return USE_MEMORY;   // Loads and stores
		return USE_ADDER;
	endfunction

	function automatic logic unit_free(input fu_select_e fu, input fu_avail_t av);
		case (fu)
			USE_MULTIPLIER: return av.mult;
			USE_ADDER:      return av.adder;
			USE_MEMORY:     return av.memory;
			default:        return 1'b0;
		endcase
	endfunction

	// Waiting operand takes a broadcast value, cdb1 first
	function automatic src_t snoop(input src_t s, input cdb_t c1, input cdb_t c2);
		src_t r;
		r = s;
		if (!s.ready && c1.valid && (c1.tag == s.word.tv.tag)) begin
			r.word.value = c1.value;
			r.ready      = 1'b1;
		end else if (!s.ready && c2.valid && (c2.tag == s.word.tv.tag)) begin
			r.word.value = c2.value;
			r.ready      = 1'b1;
		end
		return r;
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("** Error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare, then step the model
	////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		int g;   // Expected issue slot
		int f;   // Expected alloc slot
		g = -1;
		f = -1;
		if (!rst_n) begin
			m_busy = '0;   // All free
		end else begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if ((g < 0) && m_busy[i] && m[i].opa.ready && m[i].opb.ready
						&& unit_free(m[i].fu, avail))
					g = i;   // Lowest ready with its unit open
				if ((f < 0) && !m_busy[i])
					f = i;
			end
			compare("full", 64'(f < 0), 64'(full));
			compare("iss.valid", 64'(g >= 0), 64'(iss.valid));
			if (g >= 0) begin
				compare("iss.opa", m[g].opa.word.value, iss.opa);
				compare("iss.opb", m[g].opb.word.value, iss.opb);
				compare("iss.dest", 64'(m[g].dest), 64'(iss.dest));
				compare("iss.rob_idx", 64'(m[g].rob_idx), 64'(iss.rob_idx));
				compare("iss.op_type", 64'(m[g].op_type), 64'(iss.op_type));
				compare("iss.alu_func", 64'(m[g].alu_func), 64'(iss.alu_func));
				m_busy[g] = 1'b0;   // Unit takes it at this edge
			end
			for (int i = 0; i < RS_SIZE; i++) begin
				if (m_busy[i]) begin
					m[i].opa = snoop(m[i].opa, cdb1, cdb2);
					m[i].opb = snoop(m[i].opb, cdb1, cdb2);
				end
			end
			if (load && (f >= 0)) begin   // Load while full is dropped
				m[f].opa      = snoop(disp.opa, cdb1, cdb2);
				m[f].opb      = snoop(disp.opb, cdb1, cdb2);
				m[f].dest     = disp.dest;
				m[f].rob_idx  = disp.rob_idx;
				m[f].op_type  = disp.op_type;
				m[f].alu_func = disp.alu_func;
				m[f].fu       = classify(disp.op_type, disp.alu_func);
				m_busy[f]     = 1'b1;
			end
		end
		held_cnt = $countones(m_busy);
	end

endmodule

//--- tests/rs_tb.sv
// Seeded random run; every waiting tag lies in the tag window so each drain can empty the station
module rs_tb;
	import rs_pkg::*;

	localparam int RS_SIZE = 4;
	localparam int TAG_WIN = 8;            // Power of two, frequent matches
	localparam int N_READY = 60;
	localparam int N_TAGS  = 120;
	localparam int N_BP    = 60;           // Per blocked unit
	localparam int N_FULL  = RS_SIZE + 4;
	localparam int MAX_CYC = 13 + N_READY + N_TAGS + 3 * N_BP + N_FULL + 6 * 30 + 100;

	logic      clock = 1'b0;
	logic      rst_n;
	dispatch_t disp;
	logic      load;
	cdb_t      cdb1;
	cdb_t      cdb2;
	fu_avail_t avail;
	issue_t    iss;
	logic      full;
	int        seed;
	int        cycles = 0;
	int        last_err;
	int        errors;
	int        checks;
	int        held;             // Model occupancy
	string     unit_name [3] = '{"memory", "adder", "mult"};

	always #2 clock = ~clock;   // Period 4

	rs_top #(.RS_SIZE(RS_SIZE)) uut (
		.clock(clock), .rst_n(rst_n), .disp(disp), .load(load),
		.cdb1(cdb1), .cdb2(cdb2), .avail(avail), .iss(iss), .full(full)
	);

	rs_checker #(.RS_SIZE(RS_SIZE)) u_checker (
		.clock(clock), .rst_n(rst_n), .disp(disp), .load(load),
		.cdb1(cdb1), .cdb2(cdb2), .avail(avail), .iss(iss), .full(full),
		.errors(errors), .checks(checks), .held(held)
	);

	////////////////////////////////////////////////////////////
	// Random stimulus
	////////////////////////////////////////////////////////////
	function automatic src_t rand_src(input logic force_ready);
		src_t s;
		s.word.value = {$random(seed), $random(seed)};
		s.ready      = force_ready | 1'($random(seed));
		if (!s.ready)
			s.word.tv.tag = 6'($random(seed)) & 6'(TAG_WIN - 1);   // Tag in window
		return s;
	endfunction

	function automatic dispatch_t rand_disp(input logic force_ready);
		dispatch_t d;
		d.opa      = rand_src(force_ready);
		d.opb      = rand_src(force_ready);
		d.dest     = 6'($random(seed));
		d.rob_idx  = 5'($random(seed));
		d.op_type  = 6'($random(seed));
		d.alu_func = alu_func_e'(5'($unsigned($random(seed)) % 6));
		if (($random(seed) & 3) == 0) begin
			d.op_type[5:3] = 3'b010;   // Steer toward the multiplier
			d.alu_func     = ALU_MULQ;
		end
		return d;
	endfunction

	function automatic cdb_t rand_cdb(input logic en);
		cdb_t c;
		c.valid = en & 1'($random(seed));
		c.tag   = 6'($random(seed)) & 6'(TAG_WIN - 1);
		c.value = {$random(seed), $random(seed)};
		return c;
	endfunction

	task automatic drive_cycle(input logic do_load, input logic all_ready, input logic use_cdb,
			input fu_avail_t av);
		@(negedge clock);
		load  = do_load;
		disp  = rand_disp(all_ready);
		avail = av;
		cdb1  = rand_cdb(use_cdb);
		cdb2  = rand_cdb(use_cdb);
		if (($random(seed) & 7) == 0)
			cdb2.tag = cdb1.tag;   // Tie on both buses
	endtask

	// Idle loads, all units open, every window tag broadcast in turn
	task automatic drain();
		int k;
		k = 0;
		do begin
			@(negedge clock);
			load        = 1'b0;
			avail       = '1;
			cdb1.valid  = 1'b1;
			cdb1.tag    = 6'(k % TAG_WIN);
			cdb1.value  = {$random(seed), $random(seed)};
			cdb2.valid  = 1'b1;
			cdb2.tag    = 6'((k + 1) % TAG_WIN);
			cdb2.value  = {$random(seed), $random(seed)};
			k           = k + 2;
		end while (held != 0);
	endtask

	task automatic report(input string name);
		$display("%-14s finished at cycle %0d with %0d errors", name, cycles, errors - last_err);
		last_err = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Run limit
	////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////
	initial begin
		fu_avail_t av;
		seed     = 88390;
		last_err = 0;
		rst_n    = 1'b0;
		load     = 1'b0;
		disp     = '0;
		cdb1     = '0;
		cdb2     = '0;
		avail    = '1;
		repeat (10) @(negedge clock);
		rst_n = 1'b1;
		repeat (3) drive_cycle(1'b0, 1'b1, 1'b0, fu_avail_t'(3'($random(seed))));
		report("reset");
		repeat (N_READY) drive_cycle(1'($random(seed)), 1'b1, 1'b0, '1);
		drain();
		report("ready issue");
		repeat (N_TAGS) drive_cycle(1'($random(seed)), 1'b0, 1'b1, '1);
		drain();
		report("cdb capture");
		for (int u = 0; u < 3; u++) begin
			repeat (N_BP) begin
				av = fu_avail_t'(3'($random(seed)) & ~(3'b001 << u));   // One unit held low
				drive_cycle(1'($random(seed)), 1'b0, 1'b1, av);
			end
			drain();
			report({"blocked ", unit_name[u]});
		end
		repeat (N_FULL) drive_cycle(1'b1, 1'b1, 1'b0, '0);   // Issue blocked, station fills
		drain();
		report("full");
		$display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
source/rs_pkg.sv
source/rs_entry.sv
source/rs_control.sv
source/rs_issue_mux.sv
source/rs_top.sv
tests/rs_checker.sv
tests/rs_tb.sv

//--- Makefile
# Verilator build and run of the reservation station testbench

SRCS := $(wildcard source/*.sv tests/*.sv)
BIN  := obj_dir/Vrs_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module rs_tb -f files.f -o Vrs_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
